//--- Makefile
# Verilator build of the vector execution stage testbench

VERILATOR ?= verilator
TOP       ?= vector_fus_stage_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
source/lane_cfg_pkg.sv
source/vfu_op_pkg.sv
source/valu.sv
source/vmul.sv
source/vector_fus_stage.sv
tests/vector_fus_stage_tb.sv

//--- source/lane_cfg_pkg.sv
// One lane with fixed 64-bit elements; sizes are set here and are not parameters of the modules
package lane_cfg_pkg;

  // Element width and its byte enables
  localparam int unsigned ElenW = 64;
  localparam int unsigned StrbW = ElenW / 8;

  // Instructions that can be in flight, one done bit each
  localparam int unsigned NrVInsn = 4;
  localparam int unsigned VidW    = $clog2(NrVInsn);

  // Register file word address and vector length field
  localparam int unsigned VAddrW = 10;
  localparam int unsigned VlW    = 8;

  // One element per beat
  typedef logic [ElenW-1:0] elen_t;

  typedef logic [VidW-1:0] vid_t;

  typedef logic [VAddrW-1:0] vaddr_t;

  // Element count of one instruction
  typedef logic [VlW-1:0] vlen_t;

  typedef logic [StrbW-1:0] strb_t;

endpackage : lane_cfg_pkg

//--- source/valu.sv
`timescale 1ns/1ps
// One ALU instruction at a time, vl must be nonzero, both operand slots are used by every opcode
module valu (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // Lane sequencer
  input  vfu_op_pkg::vfu_operation_t       vfu_operation_i,
  input  logic                             vfu_operation_valid_i,
  output logic                             alu_ready_o,
  output logic [lane_cfg_pkg::NrVInsn-1:0] alu_vinsn_done_o,
  // Operand queues
  input  lane_cfg_pkg::elen_t [1:0]        alu_operand_i,
  input  logic [1:0]                       alu_operand_valid_i,
  output logic [1:0]                       alu_operand_ready_o,
  // Mask beats
  input  lane_cfg_pkg::strb_t              mask_i,
  input  logic                             mask_valid_i,
  output logic                             mask_ready_o,
  // Register file write port
  output logic                             alu_result_req_o,
  output vfu_op_pkg::vrf_wr_t              alu_result_o,
  input  logic                             alu_result_gnt_i
);
  import lane_cfg_pkg::*;
  import vfu_op_pkg::*;

  // Latched instruction
  unit_state_e state_q;
  vfu_op_e     op_q;
  vid_t        id_q;
  vlen_t       vl_q;
  vaddr_t      vd_q;
  logic        vm_q;
  // Index of the next element to compute
  vlen_t       cnt_q;

  // Result register
  logic               res_valid_q;
  logic               res_last_q;
  vrf_wr_t            res_q;
  logic [NrVInsn-1:0] done_q;

  logic  is_alu_op;
  logic  accept;
  logic  can_issue;
  logic  beat_valid;
  logic  fire;
  logic  last_gnt;
  elen_t alu_res;

  assign is_alu_op = vfu_operation_i.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                                OP_XOR, OP_MIN, OP_MAX};
  assign alu_ready_o = (state_q == IDLE);
  assign accept      = vfu_operation_valid_i && is_alu_op && alu_ready_o;

  // Register must be free or drain in this cycle
  assign can_issue  = (state_q == BUSY) && (cnt_q != vl_q) &&
                      (!res_valid_q || alu_result_gnt_i);
  assign beat_valid = &alu_operand_valid_i && (!vm_q || mask_valid_i);
  assign fire       = can_issue && beat_valid;

  assign alu_operand_ready_o = {2{fire}};
  assign mask_ready_o        = fire && vm_q;

  always_comb begin
    case (op_q)
      OP_ADD:  alu_res = alu_operand_i[0] + alu_operand_i[1];
      OP_SUB:  alu_res = alu_operand_i[0] - alu_operand_i[1];
      OP_AND:  alu_res = alu_operand_i[0] & alu_operand_i[1];
      OP_OR:   alu_res = alu_operand_i[0] | alu_operand_i[1];
      OP_XOR:  alu_res = alu_operand_i[0] ^ alu_operand_i[1];
      OP_MIN:  alu_res = ($signed(alu_operand_i[0]) < $signed(alu_operand_i[1])) ?
                         alu_operand_i[0] : alu_operand_i[1];
      OP_MAX:  alu_res = ($signed(alu_operand_i[0]) > $signed(alu_operand_i[1])) ?
                         alu_operand_i[0] : alu_operand_i[1];
      default: alu_res = '0;
    endcase
  end

  assign last_gnt = res_valid_q && res_last_q && alu_result_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
      done_q      <= '0;
    end else begin
      done_q <= '0;
      if (accept) begin
        state_q <= BUSY;
        cnt_q   <= '0;
      end
      if (fire) begin
        cnt_q       <= cnt_q + 1'b1;
        res_valid_q <= 1'b1;
      end else if (alu_result_gnt_i) begin
        res_valid_q <= 1'b0;
      end
      // Back to IDLE together with the done pulse
      if (last_gnt) begin
        state_q      <= IDLE;
        done_q[id_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= vfu_operation_i.op;
      id_q <= vfu_operation_i.id;
      vl_q <= vfu_operation_i.vl;
      vd_q <= vfu_operation_i.vd;
      vm_q <= vfu_operation_i.vm;
    end
    if (fire) begin
      res_q.id    <= id_q;
      res_q.addr  <= vd_q + vaddr_t'(cnt_q);
      res_q.wdata <= alu_res;
      res_q.be    <= vm_q ? mask_i : '1;
      res_last_q  <= (cnt_q == vl_q - 1'b1);
    end
  end

  assign alu_result_req_o = res_valid_q;
  assign alu_result_o     = res_q;
  assign alu_vinsn_done_o = done_q;

  // Write port payload holds until granted
  a_result_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    alu_result_req_o && !alu_result_gnt_i |=> alu_result_req_o && $stable(alu_result_o))
    else $error("valu: result changed while request pending");

  // Sequencer only strobes an ALU opcode when the unit is idle
  a_issue_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    vfu_operation_valid_i && is_alu_op |-> alu_ready_o)
    else $error("valu: operation strobed while busy");

endmodule : valu

//--- source/vector_fus_stage.sv
`timescale 1ns/1ps
// Execution stage of one lane; masked instructions must never run on both units at the same time
module vector_fus_stage (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // Lane sequencer
  input  vfu_op_pkg::vfu_operation_t       vfu_operation_i,
  input  logic                             vfu_operation_valid_i,
  output logic                             alu_ready_o,
  output logic [lane_cfg_pkg::NrVInsn-1:0] alu_vinsn_done_o,
  output logic                             mfpu_ready_o,
  output logic [lane_cfg_pkg::NrVInsn-1:0] mfpu_vinsn_done_o,
  // Operand queues
  input  lane_cfg_pkg::elen_t [1:0]        alu_operand_i,
  input  logic [1:0]                       alu_operand_valid_i,
  output logic [1:0]                       alu_operand_ready_o,
  input  lane_cfg_pkg::elen_t [2:0]        mfpu_operand_i,
  input  logic [2:0]                       mfpu_operand_valid_i,
  output logic [2:0]                       mfpu_operand_ready_o,
  // Register file write ports
  output logic                             alu_result_req_o,
  output vfu_op_pkg::vrf_wr_t              alu_result_o,
  input  logic                             alu_result_gnt_i,
  output logic                             mfpu_result_req_o,
  output vfu_op_pkg::vrf_wr_t              mfpu_result_o,
  input  logic                             mfpu_result_gnt_i,
  // Shared mask queue
  input  lane_cfg_pkg::strb_t              mask_i,
  input  logic                             mask_valid_i,
  output logic                             mask_ready_o
);

  logic alu_mask_ready;
  logic mfpu_mask_ready;

  // Only the unit running a masked instruction pulls mask beats
  assign mask_ready_o = alu_mask_ready | mfpu_mask_ready;

  valu i_valu (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .vfu_operation_i      (vfu_operation_i),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .alu_ready_o          (alu_ready_o),
    .alu_vinsn_done_o     (alu_vinsn_done_o),
    .alu_operand_i        (alu_operand_i),
    .alu_operand_valid_i  (alu_operand_valid_i),
    .alu_operand_ready_o  (alu_operand_ready_o),
    .mask_i               (mask_i),
    .mask_valid_i         (mask_valid_i),
    .mask_ready_o         (alu_mask_ready),
    .alu_result_req_o     (alu_result_req_o),
    .alu_result_o         (alu_result_o),
    .alu_result_gnt_i     (alu_result_gnt_i)
  );

  vmul i_vmul (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .vfu_operation_i      (vfu_operation_i),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .mfpu_ready_o         (mfpu_ready_o),
    .mfpu_vinsn_done_o    (mfpu_vinsn_done_o),
    .mfpu_operand_i       (mfpu_operand_i),
    .mfpu_operand_valid_i (mfpu_operand_valid_i),
    .mfpu_operand_ready_o (mfpu_operand_ready_o),
    .mask_i               (mask_i),
    .mask_valid_i         (mask_valid_i),
    .mask_ready_o         (mfpu_mask_ready),
    .mfpu_result_req_o    (mfpu_result_req_o),
    .mfpu_result_o        (mfpu_result_o),
    .mfpu_result_gnt_i    (mfpu_result_gnt_i)
  );

  // Both units consuming the same mask beat would corrupt one of them
  a_mask_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(alu_mask_ready && mfpu_mask_ready))
    else $error("vector_fus_stage: both units took a mask beat");

endmodule : vector_fus_stage

//--- source/vfu_op_pkg.sv
// Opcodes and records of the execution stage; min/max and mulh are signed, encodings 10 to 15 unused
package vfu_op_pkg;

  // Opcodes, ALU group first, then the multiplier group
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_MIN  = 4'd5,
    OP_MAX  = 4'd6,
    OP_MUL  = 4'd7,
    OP_MULH = 4'd8,
    OP_MACC = 4'd9
  } vfu_op_e;

  // Unit FSM
  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } unit_state_e;

  // Operation record from the lane sequencer
  typedef struct packed {
    lane_cfg_pkg::vid_t   id;
    vfu_op_e              op;
    lane_cfg_pkg::vlen_t  vl;
    // Base address of the destination
    lane_cfg_pkg::vaddr_t vd;
    // Set for a masked instruction
    logic                 vm;
    logic [7:0]           rsvd;
  } vfu_operation_t;

  // Write request towards the vector register file
  typedef struct packed {
    lane_cfg_pkg::vid_t   id;
    lane_cfg_pkg::vaddr_t addr;
    lane_cfg_pkg::elen_t  wdata;
    lane_cfg_pkg::strb_t  be;
  } vrf_wr_t;

endpackage : vfu_op_pkg

//--- source/vmul.sv
`timescale 1ns/1ps
// One multiply instruction at a time, vl must be nonzero; at most two elements in flight in total
module vmul (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // Lane sequencer
  input  vfu_op_pkg::vfu_operation_t       vfu_operation_i,
  input  logic                             vfu_operation_valid_i,
  output logic                             mfpu_ready_o,
  output logic [lane_cfg_pkg::NrVInsn-1:0] mfpu_vinsn_done_o,
  // Operand queues, slot 2 is the addend of OP_MACC
  input  lane_cfg_pkg::elen_t [2:0]        mfpu_operand_i,
  input  logic [2:0]                       mfpu_operand_valid_i,
  output logic [2:0]                       mfpu_operand_ready_o,
  // Mask beats
  input  lane_cfg_pkg::strb_t              mask_i,
  input  logic                             mask_valid_i,
  output logic                             mask_ready_o,
  // Register file write port
  output logic                             mfpu_result_req_o,
  output vfu_op_pkg::vrf_wr_t              mfpu_result_o,
  input  logic                             mfpu_result_gnt_i
);
  import lane_cfg_pkg::*;
  import vfu_op_pkg::*;

  // First stage carries the full product and the element's side data
  typedef struct packed {
    vaddr_t             addr;
    strb_t              be;
    logic               last;
    elen_t              addend;
    logic [2*ElenW-1:0] prod;
  } mul_stage_t;

  typedef struct packed {
    logic    last;
    vrf_wr_t wr;
  } res_entry_t;

  unit_state_e state_q;
  vfu_op_e     op_q;
  vid_t        id_q;
  vlen_t       vl_q;
  vaddr_t      vd_q;
  logic        vm_q;
  vlen_t       cnt_q;

  logic       s1_valid_q;
  mul_stage_t s1_q;
  logic       s2_valid_q;
  res_entry_t s2_q;

  // Two-entry result buffer
  res_entry_t buf_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] buf_cnt_q;
  // Elements issued but not yet granted
  logic [1:0] inflight_q;

  logic [NrVInsn-1:0] done_q;

  logic               is_mul_op;
  logic               accept;
  logic [2:0]         needed;
  logic               can_issue;
  logic               beat_valid;
  logic               fire;
  logic [2*ElenW-1:0] prod_d;
  elen_t              mul_res;
  res_entry_t         head;
  logic               req;
  logic               pop;
  logic               pop_buf;
  logic               push;

  assign is_mul_op    = vfu_operation_i.op inside {OP_MUL, OP_MULH, OP_MACC};
  assign mfpu_ready_o = (state_q == IDLE);
  assign accept       = vfu_operation_valid_i && is_mul_op && mfpu_ready_o;

  assign needed     = (op_q == OP_MACC) ? 3'b111 : 3'b011;
  assign can_issue  = (state_q == BUSY) && (cnt_q != vl_q) &&
                      ((inflight_q != 2'd2) || pop);
  assign beat_valid = &(mfpu_operand_valid_i | ~needed) && (!vm_q || mask_valid_i);
  assign fire       = can_issue && beat_valid;

  assign mfpu_operand_ready_o = needed & {3{fire}};
  assign mask_ready_o         = fire && vm_q;

  assign prod_d = $signed(mfpu_operand_i[0]) * $signed(mfpu_operand_i[1]);

  // Second stage selects the half or adds the addend
  always_comb begin
    case (op_q)
      OP_MULH: mul_res = s1_q.prod[2*ElenW-1:ElenW];
      OP_MACC: mul_res = s1_q.prod[ElenW-1:0] + s1_q.addend;
      default: mul_res = s1_q.prod[ElenW-1:0];
    endcase
  end

  // Stage 2 falls through to the port while the buffer is empty
  assign head    = (buf_cnt_q != 2'd0) ? buf_q[rd_ptr_q] : s2_q;
  assign req     = (buf_cnt_q != 2'd0) || s2_valid_q;
  assign pop     = req && mfpu_result_gnt_i;
  assign pop_buf = pop && (buf_cnt_q != 2'd0);
  assign push    = s2_valid_q && !(buf_cnt_q == 2'd0 && mfpu_result_gnt_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= IDLE;
      cnt_q      <= '0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
      buf_cnt_q  <= '0;
      inflight_q <= '0;
      done_q     <= '0;
    end else begin
      done_q     <= '0;
      s1_valid_q <= fire;
      s2_valid_q <= s1_valid_q;
      if (accept) begin
        state_q <= BUSY;
        cnt_q   <= '0;
      end
      if (fire) cnt_q <= cnt_q + 1'b1;
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop_buf) rd_ptr_q <= ~rd_ptr_q;
      buf_cnt_q  <= buf_cnt_q + 2'(push) - 2'(pop_buf);
      inflight_q <= inflight_q + 2'(fire) - 2'(pop);
      if (pop && head.last) begin
        state_q      <= IDLE;
        done_q[id_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= vfu_operation_i.op;
      id_q <= vfu_operation_i.id;
      vl_q <= vfu_operation_i.vl;
      vd_q <= vfu_operation_i.vd;
      vm_q <= vfu_operation_i.vm;
    end
    if (fire) begin
      s1_q.addr   <= vd_q + vaddr_t'(cnt_q);
      s1_q.be     <= vm_q ? mask_i : '1;
      s1_q.last   <= (cnt_q == vl_q - 1'b1);
      s1_q.addend <= mfpu_operand_i[2];
      s1_q.prod   <= prod_d;
    end
    if (s1_valid_q) begin
      s2_q.last     <= s1_q.last;
      s2_q.wr.id    <= id_q;
      s2_q.wr.addr  <= s1_q.addr;
      s2_q.wr.wdata <= mul_res;
      s2_q.wr.be    <= s1_q.be;
    end
    if (push) buf_q[wr_ptr_q] <= s2_q;
  end

  assign mfpu_result_req_o = req;
  assign mfpu_result_o     = head.wr;
  assign mfpu_vinsn_done_o = done_q;

  a_result_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mfpu_result_req_o && !mfpu_result_gnt_i |=> mfpu_result_req_o && $stable(mfpu_result_o))
    else $error("vmul: result changed while request pending");

  a_issue_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    vfu_operation_valid_i && is_mul_op |-> mfpu_ready_o)
    else $error("vmul: operation strobed while busy");

  // Issue credit keeps the pipeline from pushing into a full buffer
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    !(push && !pop_buf && buf_cnt_q == 2'd2))
    else $error("vmul: result buffer overflow");

endmodule : vmul

//--- tests/vector_fus_stage_tb.sv
`timescale 1ns/1ps
// One record per cycle on the shared operation bus; masked work never runs on both units at once
module vector_fus_stage_tb;
  import lane_cfg_pkg::*;
  import vfu_op_pkg::*;

  localparam int unsigned Seed        = 32'h6d2d_2eba;
  localparam int          ResetCycles = 5;
  localparam int          NumInsn     = 21;
  localparam int          MaxVl       = 8;
  // Sampling point after the falling edge, once all inputs have settled
  localparam int          Settle      = 2;

  typedef struct packed {
    vrf_wr_t            wr;
    logic               last;
    logic [NrVInsn-1:0] done;
  } exp_t;

  logic               clk_i;
  logic               reset_i;
  vfu_operation_t     vfu_operation_i;
  logic               vfu_operation_valid_i;
  logic               alu_ready_o;
  logic               mfpu_ready_o;
  logic [NrVInsn-1:0] alu_vinsn_done_o;
  logic [NrVInsn-1:0] mfpu_vinsn_done_o;
  elen_t [1:0]        alu_operand_i;
  logic [1:0]         alu_operand_valid_i;
  logic [1:0]         alu_operand_ready_o;
  elen_t [2:0]        mfpu_operand_i;
  logic [2:0]         mfpu_operand_valid_i;
  logic [2:0]         mfpu_operand_ready_o;
  logic               alu_result_req_o;
  logic               mfpu_result_req_o;
  vrf_wr_t            alu_result_o;
  vrf_wr_t            mfpu_result_o;
  logic               alu_result_gnt_i;
  logic               mfpu_result_gnt_i;
  strb_t              mask_i;
  logic               mask_valid_i;
  logic               mask_ready_o;

  // Reference queues, front entry is the next write each port must present
  exp_t               alu_q[$];
  exp_t               mul_q[$];
  exp_t               alu_exp;
  exp_t               mul_exp;
  logic               alu_exp_valid;
  logic               mul_exp_valid;
  logic [NrVInsn-1:0] alu_done_exp;
  logic [NrVInsn-1:0] mul_done_exp;
  logic               alu_granted;
  logic               mul_granted;
  int                 gnt_pct;
  int                 gap_pct;
  int                 max_inflight;
  int                 errors;
  int                 err_mark;
  int                 n_tests;
  int                 n_failed;
  string              test_name;
  vid_t               next_id;

  vector_fus_stage uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Each element may take up to 40 cycles under heavy back-pressure
  initial begin
    repeat (ResetCycles + NumInsn * MaxVl * 40) @(posedge clk_i);
    $display("watchdog: run did not finish in time, a unit stopped making progress");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic report_err(string what, logic [127:0] exp_v, logic [127:0] act_v);
    errors++;
    $display("ERR %s %s: expected %0h actual %0h", test_name, what, exp_v, act_v);
  endtask

  function automatic elen_t rand_elem();
    return {$urandom, $urandom};
  endfunction

  function automatic elen_t alu_expect(vfu_op_e op, elen_t a, elen_t b);
    // Flipping the sign bit turns the signed order into an unsigned one
    elen_t sa;
    elen_t sb;
    sa = a ^ {1'b1, {(ElenW-1){1'b0}}};
    sb = b ^ {1'b1, {(ElenW-1){1'b0}}};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MIN:  return (sa < sb) ? a : b;
      default: return (sa > sb) ? a : b;
    endcase
  endfunction

  function automatic elen_t mul_expect(vfu_op_e op, elen_t a, elen_t b, elen_t c);
    logic signed [2*ElenW-1:0] p;
    p = $signed({{ElenW{a[ElenW-1]}}, a}) * $signed({{ElenW{b[ElenW-1]}}, b});
    case (op)
      OP_MULH: return p[2*ElenW-1:ElenW];
      OP_MACC: return p[ElenW-1:0] + c;
      default: return p[ElenW-1:0];
    endcase
  endfunction

  function automatic vfu_operation_t make_op(vfu_op_e op, logic vm, int vl_min);
    vfu_operation_t rec;
    rec    = '0;
    rec.id = next_id;
    rec.op = op;
    rec.vl = vlen_t'($urandom_range(MaxVl, vl_min));
    rec.vd = vaddr_t'($urandom);
    rec.vm = vm;
    next_id = next_id + 1'b1;
    return rec;
  endfunction

  function automatic exp_t entry(vfu_operation_t rec, int idx, elen_t wdata, strb_t m);
    exp_t e;
    e.wr.id    = rec.id;
    e.wr.addr  = rec.vd + vaddr_t'(idx);
    e.wr.wdata = wdata;
    e.wr.be    = rec.vm ? m : '1;
    e.last     = (idx == int'(rec.vl) - 1);
    e.done     = '0;
    e.done[rec.id] = 1'b1;
    return e;
  endfunction

  task automatic issue(vfu_operation_t rec);
    logic is_mul;
    is_mul = rec.op inside {OP_MUL, OP_MULH, OP_MACC};
    @(negedge clk_i);
    while (is_mul ? !mfpu_ready_o : !alu_ready_o) @(negedge clk_i);
    vfu_operation_i       = rec;
    vfu_operation_valid_i = 1'b1;
    @(negedge clk_i);
    vfu_operation_valid_i = 1'b0;
  endtask

  task automatic feed_alu(vfu_operation_t rec);
    elen_t      a;
    elen_t      b;
    strb_t      m;
    logic       fired;
    logic [2:0] rdy_exp;
    logic [2:0] rdy_act;
    for (int i = 0; i < int'(rec.vl); i++) begin
      a = rand_elem();
      b = rand_elem();
      m = strb_t'($urandom);
      fired = 1'b0;
      while (!fired) begin
        @(negedge clk_i);
        alu_operand_i[0]    = a;
        alu_operand_i[1]    = b;
        alu_operand_valid_i = ($urandom_range(99) < gap_pct) ? 2'b00 : 2'b11;
        if (rec.vm) begin
          mask_i       = m;
          mask_valid_i = alu_operand_valid_i[0];
        end
        #(Settle);
        fired = alu_operand_ready_o[0];
        // Both slots and a needed mask beat are taken in the same beat
        rdy_exp = {rec.vm && fired, {2{fired}}};
        rdy_act = {rec.vm && mask_ready_o, alu_operand_ready_o};
        assert (rdy_act == rdy_exp)
          else report_err("alu ready", 128'(rdy_exp), 128'(rdy_act));
      end
      alu_q.push_back(entry(rec, i, alu_expect(rec.op, a, b), m));
    end
    @(negedge clk_i);
    alu_operand_valid_i = '0;
    if (rec.vm) mask_valid_i = 1'b0;
  endtask

  task automatic feed_mul(vfu_operation_t rec);
    elen_t      a;
    elen_t      b;
    elen_t      c;
    strb_t      m;
    logic       fired;
    logic [2:0] slots;
    logic [3:0] rdy_exp;
    logic [3:0] rdy_act;
    // The addend slot is only taken by OP_MACC
    slots = (rec.op == OP_MACC) ? 3'b111 : 3'b011;
    for (int i = 0; i < int'(rec.vl); i++) begin
      a = rand_elem();
      b = rand_elem();
      c = rand_elem();
      m = strb_t'($urandom);
      // First element always has a negative multiplicand
      if (i == 0) a[ElenW-1] = 1'b1;
      fired = 1'b0;
      while (!fired) begin
        @(negedge clk_i);
        mfpu_operand_i[0]    = a;
        mfpu_operand_i[1]    = b;
        mfpu_operand_i[2]    = c;
        mfpu_operand_valid_i = ($urandom_range(99) < gap_pct) ? 3'b000 : 3'b111;
        if (rec.vm) begin
          mask_i       = m;
          mask_valid_i = mfpu_operand_valid_i[0];
        end
        #(Settle);
        fired = mfpu_operand_ready_o[0];
        rdy_exp = {rec.vm && fired, slots & {3{fired}}};
        rdy_act = {rec.vm && mask_ready_o, mfpu_operand_ready_o};
        assert (rdy_act == rdy_exp)
          else report_err("mul ready", 128'(rdy_exp), 128'(rdy_act));
      end
      mul_q.push_back(entry(rec, i, mul_expect(rec.op, a, b, c), m));
    end
    @(negedge clk_i);
    mfpu_operand_valid_i = '0;
    if (rec.vm) mask_valid_i = 1'b0;
  endtask

  task automatic run_one(vfu_op_e op, logic vm, int vl_min);
    vfu_operation_t rec;
    rec = make_op(op, vm, vl_min);
    issue(rec);
    if (op inside {OP_MUL, OP_MULH, OP_MACC}) feed_mul(rec);
    else feed_alu(rec);
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
      #(Settle);
    end while (alu_q.size() != 0 || mul_q.size() != 0 || !alu_ready_o || !mfpu_ready_o);
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    wait_idle();
    repeat (2) @(negedge clk_i);
    n_tests++;
    if (errors != err_mark) n_failed++;
    $display("test %-12s %s", test_name, (errors == err_mark) ? "ok" : "failed");
  endtask

  // Grant driver, pops an entry once its grant has been taken at the rising edge
  initial begin
    alu_result_gnt_i  = 1'b0;
    mfpu_result_gnt_i = 1'b0;
    alu_granted       = 1'b0;
    mul_granted       = 1'b0;
    alu_exp_valid     = 1'b0;
    mul_exp_valid     = 1'b0;
    alu_done_exp      = '0;
    mul_done_exp      = '0;
    forever begin
      @(negedge clk_i);
      alu_done_exp = '0;
      mul_done_exp = '0;
      if (alu_granted && alu_q.size() != 0) begin
        if (alu_q[0].last) alu_done_exp = alu_q[0].done;
        void'(alu_q.pop_front());
      end
      if (mul_granted && mul_q.size() != 0) begin
        if (mul_q[0].last) mul_done_exp = mul_q[0].done;
        void'(mul_q.pop_front());
      end
      if (mul_q.size() > max_inflight) max_inflight = mul_q.size();
      alu_exp_valid = (alu_q.size() != 0);
      mul_exp_valid = (mul_q.size() != 0);
      if (alu_exp_valid) alu_exp = alu_q[0];
      if (mul_exp_valid) mul_exp = mul_q[0];
      alu_result_gnt_i  = ($urandom_range(99) < gnt_pct);
      mfpu_result_gnt_i = ($urandom_range(99) < gnt_pct);
      #(Settle);
      alu_granted = alu_result_req_o && alu_result_gnt_i;
      mul_granted = mfpu_result_req_o && mfpu_result_gnt_i;
    end
  end

  a_alu_result: assert property (@(posedge clk_i) disable iff (reset_i)
    alu_result_req_o && alu_result_gnt_i |-> alu_exp_valid && alu_result_o == alu_exp.wr)
    else report_err("alu write", 128'(alu_exp.wr), 128'($sampled(alu_result_o)));

  a_mul_result: assert property (@(posedge clk_i) disable iff (reset_i)
    mfpu_result_req_o && mfpu_result_gnt_i |-> mul_exp_valid && mfpu_result_o == mul_exp.wr)
    else report_err("mul write", 128'(mul_exp.wr), 128'($sampled(mfpu_result_o)));

  // Done bits and ready, shown together as {done, ready}
  a_alu_done: assert property (@(posedge clk_i) disable iff (reset_i)
    (alu_vinsn_done_o != '0 || alu_done_exp != '0) |->
      {alu_vinsn_done_o, alu_ready_o} == {alu_done_exp, 1'b1})
    else report_err("alu done", 128'({alu_done_exp, 1'b1}),
                    128'($sampled({alu_vinsn_done_o, alu_ready_o})));

  a_mul_done: assert property (@(posedge clk_i) disable iff (reset_i)
    (mfpu_vinsn_done_o != '0 || mul_done_exp != '0) |->
      {mfpu_vinsn_done_o, mfpu_ready_o} == {mul_done_exp, 1'b1})
    else report_err("mul done", 128'({mul_done_exp, 1'b1}),
                    128'($sampled({mfpu_vinsn_done_o, mfpu_ready_o})));

  initial begin
    logic [17:0]    status;
    vfu_operation_t ra;
    vfu_operation_t rm;
    void'($urandom(Seed));
    reset_i               = 1'b1;
    vfu_operation_i       = '0;
    vfu_operation_valid_i = 1'b0;
    alu_operand_i         = '0;
    alu_operand_valid_i   = '0;
    mfpu_operand_i        = '0;
    mfpu_operand_valid_i  = '0;
    mask_i                = '0;
    mask_valid_i          = 1'b0;
    gnt_pct      = 60;
    gap_pct      = 10;
    max_inflight = 0;
    errors       = 0;
    n_tests      = 0;
    n_failed     = 0;
    next_id      = '0;
    repeat (ResetCycles) @(negedge clk_i);
    reset_i = 1'b0;

    start_test("reset");
    #(Settle);
    status = {alu_result_req_o, mfpu_result_req_o, alu_vinsn_done_o, mfpu_vinsn_done_o,
              alu_operand_ready_o, mfpu_operand_ready_o, alu_ready_o, mfpu_ready_o,
              mask_ready_o};
    assert (status == 18'h6) else report_err("status", 128'(18'h6), 128'(status));
    end_test();

    start_test("alu_ops");
    for (int k = 0; k <= int'(OP_MAX); k++) run_one(vfu_op_e'(k), 1'b0, 1);
    end_test();

    // Slow grants let the pipeline fill
    start_test("mul_ops");
    gnt_pct      = 30;
    max_inflight = 0;
    repeat (2) begin
      run_one(OP_MUL, 1'b0, 4);
      run_one(OP_MULH, 1'b0, 4);
      run_one(OP_MACC, 1'b0, 4);
    end
    wait_idle();
    assert (max_inflight >= 2) else begin
      errors++;
      $display("%s: the multiplier never had two products in flight", test_name);
    end
    gnt_pct = 60;
    end_test();

    start_test("masked");
    run_one(OP_XOR, 1'b1, 3);
    run_one(OP_MACC, 1'b1, 3);
    end_test();

    start_test("backpressure");
    gnt_pct = 25;
    gap_pct = 30;
    run_one(OP_SUB, 1'b0, 6);
    run_one(OP_MIN, 1'b1, 6);
    run_one(OP_MUL, 1'b0, 6);
    run_one(OP_MACC, 1'b0, 6);
    wait_idle();
    gnt_pct = 60;
    gap_pct = 10;
    end_test();

    start_test("dual");
    ra = make_op(OP_ADD, 1'b1, 4);
    rm = make_op(OP_MULH, 1'b0, 4);
    issue(ra);
    issue(rm);
    fork
      feed_alu(ra);
      feed_mul(rm);
    join
    end_test();

    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : vector_fus_stage_tb
